/* hw/memCfg.svh */
// build-time sizes for the memory system; RAM_LAT must be at least 1 and MEM_WORDS a power of two
`ifndef MEM_CFG_SVH
`define MEM_CFG_SVH

// one data word
`define WORD_W 32

// byte address as seen by the cores
`define ADDR_W 32

// RAM depth in words
// only the address bits just above the byte offset index the array
`define MEM_WORDS 256

// cycles spent in BUSY before the single ACCESS cycle
`define RAM_LAT 3

`endif

/* hw/cpuTypesPkg.sv */
// word, address and RAM state types; the widths follow memCfg.svh, so edit sizes there
`include "memCfg.svh"

package cpuTypesPkg;

  // one data word
  typedef logic [`WORD_W-1:0] wordT;

  // byte address
  // the RAM drops the two low bits
  typedef logic [`ADDR_W-1:0] addrT;

  // RAM handshake state
  // FREE    idle, a strobe seen at the edge starts an access
  // BUSY    latency countdown
  // ACCESS  read data valid, write commits at the closing edge
  // ERROR   both strobes high at once
  typedef enum logic [1:0] {
    FREE,
    BUSY,
    ACCESS,
    ERROR
  } ramStateT;

endpackage

/* hw/arbTypesPkg.sv */
// arbitration types for the two-core controller; the port set is fixed at two cores
package arbTypesPkg;

  // owner of the shared RAM in the current cycle
  // listed from highest to lowest priority after GNT_NONE
  typedef enum logic [2:0] {
    GNT_NONE,
    // core 0 data port
    GNT_D0,
    // core 1 data port
    GNT_D1,
    // core 0 instruction port
    GNT_I0,
    // core 1 instruction port
    GNT_I1
  } grantT;

endpackage

/* hw/memoryControl.sv */
// combinational two-core RAM arbiter; a core must hold its request until its wait drops
`timescale 1ns/10ps

module memoryControl (
  // instruction side
  input  logic [1:0]             iRen,
  input  cpuTypesPkg::addrT      iAddr0,
  input  cpuTypesPkg::addrT      iAddr1,
  output logic [1:0]             iWait,
  output cpuTypesPkg::wordT      iLoad0,
  output cpuTypesPkg::wordT      iLoad1,
  // data side
  input  logic [1:0]             dRen,
  input  logic [1:0]             dWen,
  input  cpuTypesPkg::addrT      dAddr0,
  input  cpuTypesPkg::addrT      dAddr1,
  input  cpuTypesPkg::wordT      dStore0,
  input  cpuTypesPkg::wordT      dStore1,
  output logic [1:0]             dWait,
  output cpuTypesPkg::wordT      dLoad0,
  output cpuTypesPkg::wordT      dLoad1,
  // RAM side
  input  cpuTypesPkg::wordT      ramLoad,
  input  cpuTypesPkg::ramStateT  ramState,
  output logic                   ramRen,
  output logic                   ramWen,
  output cpuTypesPkg::addrT      ramAddr,
  output cpuTypesPkg::wordT      ramStore
);
  import cpuTypesPkg::*;
  import arbTypesPkg::*;

  grantT      grant;
  logic [1:0] dReq;
  logic       done;

  // any data strobe counts as a pending data access
  assign dReq = dRen | dWen;

  // RAM finished the access it was given this cycle
  assign done = (ramState == ACCESS);

  // fixed priority: d0, d1, i0, i1
  always_comb begin
    if (dReq[0]) begin
      grant = GNT_D0;
    end else if (dReq[1]) begin
      grant = GNT_D1;
    end else if (iRen[0]) begin
      grant = GNT_I0;
    end else if (iRen[1]) begin
      grant = GNT_I1;
    end else begin
      grant = GNT_NONE;
    end
  end

  // steer the winner onto the RAM port
  always_comb begin
    ramRen   = 1'b0;
    ramWen   = 1'b0;
    ramAddr  = '0;
    ramStore = '0;
    case (grant)
      GNT_D0: begin
        // both strobes pass through so the RAM can flag ERROR
        ramRen   = dRen[0];
        ramWen   = dWen[0];
        ramAddr  = dAddr0;
        ramStore = dStore0;
      end
      GNT_D1: begin
        ramRen   = dRen[1];
        ramWen   = dWen[1];
        ramAddr  = dAddr1;
        ramStore = dStore1;
      end
      GNT_I0: begin
        ramRen  = 1'b1;
        ramAddr = iAddr0;
      end
      GNT_I1: begin
        ramRen  = 1'b1;
        ramAddr = iAddr1;
      end
      default: begin
        ramRen = 1'b0;
      end
    endcase
  end

  // only the granted port may see its wait drop
  always_comb begin
    iWait = 2'b11;
    dWait = 2'b11;
    case (grant)
      GNT_D0: begin
        dWait[0] = ~done;
      end
      GNT_D1: begin
        dWait[1] = ~done;
      end
      GNT_I0: begin
        iWait[0] = ~done;
      end
      GNT_I1: begin
        iWait[1] = ~done;
      end
      default: begin
        iWait = 2'b11;
      end
    endcase
    // a core with data in flight never sees a fetch complete
    iWait = iWait | dReq;
  end

  // load data is shared, the wait tells each port when it is meant for it
  assign iLoad0 = ramLoad;
  assign iLoad1 = ramLoad;
  assign dLoad0 = ramLoad;
  assign dLoad1 = ramLoad;

endmodule

/* hw/ramModel.sv */
// word RAM with RAM_LAT busy cycles per access; contents survive reset and start undefined
`timescale 1ns/10ps
`include "memCfg.svh"

module ramModel (
  input  logic                   CLK,
  input  logic                   rst,
  input  logic                   ramRen,
  input  logic                   ramWen,
  input  cpuTypesPkg::addrT      ramAddr,
  input  cpuTypesPkg::wordT      ramStore,
  output cpuTypesPkg::wordT      ramLoad,
  output cpuTypesPkg::ramStateT  ramState
);
  import cpuTypesPkg::*;

  localparam int idxW = $clog2(`MEM_WORDS);
  localparam int lat  = `RAM_LAT;
  localparam int cntW = $clog2(lat + 1);

  wordT            mem [`MEM_WORDS];
  ramStateT        stateQ;
  logic [cntW-1:0] latCnt;

  // request captured at the starting edge
  logic            renQ;
  logic            wenQ;
  addrT            addrQ;
  wordT            storeQ;

  logic            reqNow;
  logic            conflict;
  logic            same;
  logic [idxW-1:0] idx;

  assign reqNow   = ramRen | ramWen;
  assign conflict = ramRen & ramWen;
  assign idx      = addrQ[idxW+1:2];

  // current request still matches the captured one
  // write data is compared too, so a writer that takes over never commits stale data
  assign same = (ramRen == renQ) && (ramWen == wenQ) && (ramAddr == addrQ) &&
                (!wenQ || (ramStore == storeQ));

  // state sequence FREE -> BUSY x lat -> ACCESS -> FREE
  always_ff @(posedge CLK) begin
    if (rst) begin
      stateQ <= FREE;
      latCnt <= '0;
    end else begin
      case (stateQ)
        FREE: begin
          if (reqNow && !conflict) begin
            stateQ <= BUSY;
            latCnt <= '0;
          end
        end
        BUSY: begin
          if (!same) begin
            // request moved under us, start over
            stateQ <= FREE;
          end else if (latCnt == cntW'(lat - 1)) begin
            stateQ <= ACCESS;
          end else begin
            latCnt <= latCnt + 1'b1;
          end
        end
        ACCESS: begin
          stateQ <= FREE;
        end
        default: begin
          stateQ <= FREE;
        end
      endcase
    end
  end

  // capture while idle so the first edge of an access holds the request
  always_ff @(posedge CLK) begin
    if (stateQ == FREE) begin
      renQ   <= ramRen;
      wenQ   <= ramWen;
      addrQ  <= ramAddr;
      storeQ <= ramStore;
    end
  end

  // write lands on the edge that leaves ACCESS
  always_ff @(posedge CLK) begin
    if (!rst && stateQ == ACCESS && same && wenQ) begin
      mem[idx] <= storeQ;
    end
  end

  assign ramLoad = mem[idx];

  // ACCESS is only reported for the request that is actually being served
  always_comb begin
    if (conflict) begin
      ramState = ERROR;
    end else if (stateQ == ACCESS && !same) begin
      ramState = BUSY;
    end else begin
      ramState = stateQ;
    end
  end

endmodule

/* hw/memorySystem.sv */
// memory side of the dual-core CPU; cache ports follow the hold-until-wait-low handshake
`timescale 1ns/10ps

module memorySystem (
  input  logic               CLK,
  input  logic               rst,
  // instruction ports
  input  logic [1:0]         iRen,
  input  cpuTypesPkg::addrT  iAddr0,
  input  cpuTypesPkg::addrT  iAddr1,
  output logic [1:0]         iWait,
  output cpuTypesPkg::wordT  iLoad0,
  output cpuTypesPkg::wordT  iLoad1,
  // data ports
  input  logic [1:0]         dRen,
  input  logic [1:0]         dWen,
  input  cpuTypesPkg::addrT  dAddr0,
  input  cpuTypesPkg::addrT  dAddr1,
  input  cpuTypesPkg::wordT  dStore0,
  input  cpuTypesPkg::wordT  dStore1,
  output logic [1:0]         dWait,
  output cpuTypesPkg::wordT  dLoad0,
  output cpuTypesPkg::wordT  dLoad1
);
  import cpuTypesPkg::*;

  // shared RAM port
  logic     ramRen;
  logic     ramWen;
  addrT     ramAddr;
  wordT     ramStore;
  wordT     ramLoad;
  ramStateT ramState;

  memoryControl memoryControl_i (
    .iRen     (iRen),
    .iAddr0   (iAddr0),
    .iAddr1   (iAddr1),
    .iWait    (iWait),
    .iLoad0   (iLoad0),
    .iLoad1   (iLoad1),
    .dRen     (dRen),
    .dWen     (dWen),
    .dAddr0   (dAddr0),
    .dAddr1   (dAddr1),
    .dStore0  (dStore0),
    .dStore1  (dStore1),
    .dWait    (dWait),
    .dLoad0   (dLoad0),
    .dLoad1   (dLoad1),
    .ramLoad  (ramLoad),
    .ramState (ramState),
    .ramRen   (ramRen),
    .ramWen   (ramWen),
    .ramAddr  (ramAddr),
    .ramStore (ramStore)
  );

  ramModel ramModel_i (
    .CLK      (CLK),
    .rst      (rst),
    .ramRen   (ramRen),
    .ramWen   (ramWen),
    .ramAddr  (ramAddr),
    .ramStore (ramStore),
    .ramLoad  (ramLoad),
    .ramState (ramState)
  );

endmodule

/* verif/clockGen.sv */
// free-running testbench clock with a 100 ns period, starts low at time zero
`timescale 1ns/10ps

module clockGen (
  output logic CLK
);

  // half period in ns
  localparam int halfPeriod = 50;

  initial begin
    CLK = 1'b0;
  end

  always begin
    #halfPeriod;
    CLK = ~CLK;
  end

endmodule

/* verif/memorySystemTb.sv */
// fixed-seed random traffic on all four ports; loads are only checked for words written in this run
`timescale 1ns/10ps
`include "memCfg.svh"

module memorySystemTb;
  import cpuTypesPkg::*;
  import arbTypesPkg::*;

  localparam int idxW      = $clog2(`MEM_WORDS);
  localparam int rounds    = 4;
  localparam int rstCycles = 8;
  // two cores doing write and read per round, then eight mixed accesses
  localparam int numOps    = 2 * rounds * 2 + 8;
  localparam longint timeoutNs = longint'(numOps) * (`RAM_LAT + 2) * 4 * 100;

  logic       CLK;
  logic       rst;
  logic [1:0] iRen;
  addrT       iAddr0;
  addrT       iAddr1;
  logic [1:0] iWait;
  wordT       iLoad0;
  wordT       iLoad1;
  logic [1:0] dRen;
  logic [1:0] dWen;
  addrT       dAddr0;
  addrT       dAddr1;
  wordT       dStore0;
  wordT       dStore1;
  logic [1:0] dWait;
  wordT       dLoad0;
  wordT       dLoad1;

  // reference memory filled by completed data writes
  wordT                  refMem [`MEM_WORDS];
  logic [`MEM_WORDS-1:0] refValid;

  logic [1:0] dReq;
  // bit order is iWait[1], iWait[0], dWait[1], dWait[0]
  logic [3:0] lowBits;
  logic [3:0] prevLowBits;
  logic [3:0] expMask;
  wordT       expD0;
  wordT       expD1;
  wordT       expI0;
  wordT       expI1;
  logic       knownD0;
  logic       knownD1;
  logic       knownI0;
  logic       knownI1;

  addrT wrAddr [2][rounds];
  wordT wrData [2][rounds];
  addrT extraAddr;
  wordT extraData;

  clockGen clockGen_i (
    .CLK (CLK)
  );

  memorySystem memorySystem_i (
    .CLK     (CLK),
    .rst     (rst),
    .iRen    (iRen),
    .iAddr0  (iAddr0),
    .iAddr1  (iAddr1),
    .iWait   (iWait),
    .iLoad0  (iLoad0),
    .iLoad1  (iLoad1),
    .dRen    (dRen),
    .dWen    (dWen),
    .dAddr0  (dAddr0),
    .dAddr1  (dAddr1),
    .dStore0 (dStore0),
    .dStore1 (dStore1),
    .dWait   (dWait),
    .dLoad0  (dLoad0),
    .dLoad1  (dLoad1)
  );

  // RAM word selected by a byte address
  function automatic logic [idxW-1:0] wordIndex(input addrT addr);
    return addr[idxW+1:2];
  endfunction

  // data before instructions and core 0 before core 1
  function automatic grantT priorityWinner(input logic [1:0] fetchReq,
                                           input logic [1:0] dataReq);
    if (dataReq[0]) begin
      return GNT_D0;
    end else if (dataReq[1]) begin
      return GNT_D1;
    end else if (fetchReq[0]) begin
      return GNT_I0;
    end else if (fetchReq[1]) begin
      return GNT_I1;
    end
    return GNT_NONE;
  endfunction

  // which low wait bit a grant may produce
  function automatic logic [3:0] waitMaskOf(input grantT g);
    case (g)
      GNT_D0:  return 4'b0001;
      GNT_D1:  return 4'b0010;
      GNT_I0:  return 4'b0100;
      GNT_I1:  return 4'b1000;
      default: return 4'b0000;
    endcase
  endfunction

  task automatic reportMismatch(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
    $display("** Error: %s expected %h actual %h", name, expected, actual);
    $display("SIMULATION FAILED");
    $fatal(1, "check %s failed", name);
  endtask

  // one data access, held until its wait drops
  task automatic dataAccess(input int core, input logic isWrite, input addrT addr,
                            input wordT data);
    @(posedge CLK);
    if (core == 0) begin
      dAddr0  <= addr;
      dStore0 <= data;
    end else begin
      dAddr1  <= addr;
      dStore1 <= data;
    end
    dRen[core] <= ~isWrite;
    dWen[core] <= isWrite;
    @(negedge CLK);
    while (dWait[core]) begin
      @(negedge CLK);
    end
    @(posedge CLK);
    dRen[core] <= 1'b0;
    dWen[core] <= 1'b0;
  endtask

  // one instruction fetch, held until its wait drops
  task automatic fetch(input int core, input addrT addr);
    @(posedge CLK);
    if (core == 0) begin
      iAddr0 <= addr;
    end else begin
      iAddr1 <= addr;
    end
    iRen[core] <= 1'b1;
    @(negedge CLK);
    while (iWait[core]) begin
      @(negedge CLK);
    end
    @(posedge CLK);
    iRen[core] <= 1'b0;
  endtask

  // fetch whose strobe stays up through the FREE cycle after its wait pulse
  task automatic heldFetch(input int core, input addrT addr);
    @(posedge CLK);
    if (core == 0) begin
      iAddr0 <= addr;
    end else begin
      iAddr1 <= addr;
    end
    iRen[core] <= 1'b1;
    @(negedge CLK);
    while (iWait[core]) begin
      @(negedge CLK);
    end
    repeat (2) @(posedge CLK);
    iRen[core] <= 1'b0;
  endtask

  assign dReq    = dRen | dWen;
  assign lowBits = ~{iWait, dWait};
  assign expMask = waitMaskOf(priorityWinner(iRen, dReq));
  assign expD0   = refMem[wordIndex(dAddr0)];
  assign expD1   = refMem[wordIndex(dAddr1)];
  assign expI0   = refMem[wordIndex(iAddr0)];
  assign expI1   = refMem[wordIndex(iAddr1)];
  assign knownD0 = refValid[wordIndex(dAddr0)];
  assign knownD1 = refValid[wordIndex(dAddr1)];
  assign knownI0 = refValid[wordIndex(iAddr0)];
  assign knownI1 = refValid[wordIndex(iAddr1)];

  // a write lands when its port sees the wait drop
  always @(posedge CLK) begin
    if (!rst && dWen[0] && !dWait[0]) begin
      refMem[wordIndex(dAddr0)]   <= dStore0;
      refValid[wordIndex(dAddr0)] <= 1'b1;
    end
    if (!rst && dWen[1] && !dWait[1]) begin
      refMem[wordIndex(dAddr1)]   <= dStore1;
      refValid[wordIndex(dAddr1)] <= 1'b1;
    end
    prevLowBits <= rst ? 4'b0000 : lowBits;
  end

  idleWaitsHigh: assert property (@(posedge CLK)
    (iRen == 2'b00 && dReq == 2'b00) |-> (iWait == 2'b11 && dWait == 2'b11))
    else reportMismatch("idleWaitsHigh", 32'hf, $sampled({iWait, dWait}));

  dataLoad0: assert property (@(posedge CLK) disable iff (rst)
    (dRen[0] && !dWait[0] && knownD0) |-> dLoad0 == expD0)
    else reportMismatch("dataLoad0", $sampled(expD0), $sampled(dLoad0));

  dataLoad1: assert property (@(posedge CLK) disable iff (rst)
    (dRen[1] && !dWait[1] && knownD1) |-> dLoad1 == expD1)
    else reportMismatch("dataLoad1", $sampled(expD1), $sampled(dLoad1));

  fetchLoad0: assert property (@(posedge CLK) disable iff (rst)
    (iRen[0] && !iWait[0] && knownI0) |-> iLoad0 == expI0)
    else reportMismatch("fetchLoad0", $sampled(expI0), $sampled(iLoad0));

  fetchLoad1: assert property (@(posedge CLK) disable iff (rst)
    (iRen[1] && !iWait[1] && knownI1) |-> iLoad1 == expI1)
    else reportMismatch("fetchLoad1", $sampled(expI1), $sampled(iLoad1));

  coreZeroDataFirst: assert property (@(posedge CLK) disable iff (rst)
    (dReq[0] && dReq[1]) |-> dWait[1])
    else reportMismatch("coreZeroDataFirst", 32'h1, $sampled(dWait[1]));

  dataBeforeFetch: assert property (@(posedge CLK) disable iff (rst)
    (dReq != 2'b00) |-> iWait == 2'b11)
    else reportMismatch("dataBeforeFetch", 32'h3, $sampled(iWait));

  grantOrder: assert property (@(posedge CLK) disable iff (rst)
    (lowBits != 4'b0000) |-> lowBits == expMask)
    else reportMismatch("grantOrder", $sampled(expMask), $sampled(lowBits));

  noRepeatLow: assert property (@(posedge CLK) disable iff (rst)
    (lowBits & prevLowBits) == 4'b0000)
    else reportMismatch("noRepeatLow", 32'h0, $sampled(lowBits & prevLowBits));

  singleLow: assert property (@(posedge CLK) disable iff (rst)
    $onehot0(lowBits))
    else reportMismatch("singleLow", 32'h1, $sampled(lowBits));

  initial begin : watchdog
    #(timeoutNs);
    $display("timeout: memory accesses did not complete within %0d ns", timeoutNs);
    $display("SIMULATION FAILED");
    $fatal(1, "watchdog expired");
  end

  initial begin
    void'($urandom(32'h9aab742f));
    rst         = 1'b1;
    iRen        = 2'b00;
    iAddr0      = '0;
    iAddr1      = '0;
    dRen        = 2'b00;
    dWen        = 2'b00;
    dAddr0      = '0;
    dAddr1      = '0;
    dStore0     = '0;
    dStore1     = '0;
    refValid    = '0;
    prevLowBits = 4'b0000;
    repeat (rstCycles) @(posedge CLK);
    rst <= 1'b0;
    // quiet stretch with no strobes
    repeat (4) @(posedge CLK);

    // write then read back on each core
    for (int c = 0; c < 2; c++) begin
      for (int r = 0; r < rounds; r++) begin
        wrAddr[c][r] = $urandom & ~32'h3;
        wrData[c][r] = $urandom;
        dataAccess(c, 1'b1, wrAddr[c][r], wrData[c][r]);
        dataAccess(c, 1'b0, wrAddr[c][r], '0);
      end
    end

    // both data reads rise together
    fork
      dataAccess(0, 1'b0, wrAddr[0][0], '0);
      dataAccess(1, 1'b0, wrAddr[1][0], '0);
    join

    // core 0 data write against a core 1 fetch, then fetch the new word
    extraAddr = $urandom & ~32'h3;
    extraData = $urandom;
    fork
      dataAccess(0, 1'b1, extraAddr, extraData);
      fetch(1, wrAddr[1][1]);
    join
    fetch(0, extraAddr);

    // two fetches at once
    fork
      fetch(0, wrAddr[0][2]);
      fetch(1, wrAddr[1][3]);
    join

    // a strobe left up past its wait pulse must not see a second pulse
    heldFetch(0, wrAddr[0][1]);

    repeat (4) @(posedge CLK);
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

/* sources.f */
+incdir+hw
hw/cpuTypesPkg.sv
hw/arbTypesPkg.sv
hw/memoryControl.sv
hw/ramModel.sv
hw/memorySystem.sv
verif/clockGen.sv
verif/memorySystemTb.sv

/* Makefile */
TOP := memorySystemTb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): sources.f hw/memCfg.svh hw/*.sv verif/*.sv
	verilator --binary --timing --assert -j 0 -f sources.f --top-module $(TOP) -o V$(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing --assert -f sources.f --top-module $(TOP)

clean:
	rm -rf obj_dir
